/* Bender.yml */
package:
  name: frontend

sources:
  - include_dirs:
      - .
    files:
      - fe_types_pkg.sv
      - bus_pkg.sv
      - axil_rd_if.sv
      - fetch_unit.sv
      - inst_queue.sv
      - issue_unit.sv
      - mem_arbiter.sv
      - frontend_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_frontend.sv

/* axil_rd_if.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

interface axil_rd_if;
    import bus_pkg::*;

    logic [`FE_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [`FE_LINE_W-1:0] rdata;
    axi_resp_e             rresp;
    logic                  rvalid;
    logic                  rready;

    modport manager (
        output araddr, arvalid, rready,
        input  arready, rdata, rresp, rvalid
    );

    modport subordinate (
        input  araddr, arvalid, rready,
        output arready, rdata, rresp, rvalid
    );

endinterface

/* bus_pkg.sv */
package bus_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        ADDR = 2'b01,
        DATA = 2'b10
    } arb_state_e;

    typedef logic mgr_idx_t;

    localparam mgr_idx_t MGR_FETCH = 1'b0;
    localparam mgr_idx_t MGR_ISSUE = 1'b1;

endpackage

/* fe_types_pkg.sv */
`include "frontend_config.svh"

package fe_types_pkg;

    // instruction class, taken from bits [FE_OPC_LSB +: 4]
    typedef enum logic [3:0] {
        NOP     = 4'h0,
        ALU     = 4'h1,
        LOAD    = 4'h2,
        ILLEGAL = 4'hf
    } opcode_e;

    typedef struct packed {
        logic [`FE_XLEN-1:0]   inst;
        logic [`FE_ADDR_W-1:0] pc;
    } queue_slot_t;

    typedef enum logic [1:0] {
        READY     = 2'b00,
        LOAD_ADDR = 2'b01,
        LOAD_DATA = 2'b10
    } issue_state_e;

endpackage

/* fetch_unit.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

module fetch_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      redirect,
    input  logic [`FE_ADDR_W-1:0]     redirect_pc,
    axil_rd_if.manager                bus,
    input  logic                      fifo_stall_req,
    output logic                      w_ena_1,
    output logic                      w_ena_2,
    output fe_types_pkg::queue_slot_t w_slot_1,
    output fe_types_pkg::queue_slot_t w_slot_2
);

    logic [`FE_ADDR_W-1:0] pc;
    logic [`FE_ADDR_W-1:0] ar_addr;
    logic [`FE_ADDR_W-1:0] target;
    logic                  ar_valid;
    logic                  r_wait;
    logic                  drop;
    logic                  r_fire;
    logic                  line_ok;

    assign target  = {redirect_pc[`FE_ADDR_W-1:4], 4'b0000};
    assign r_fire  = bus.rvalid && bus.rready;
    // a line that lands in the redirect cycle belongs to the old stream
    assign line_ok = r_fire && !drop && !redirect;

    assign bus.araddr  = ar_addr;
    assign bus.arvalid = ar_valid;
    assign bus.rready  = r_wait && !fifo_stall_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            ar_valid <= 1'b0;
            r_wait   <= 1'b0;
            drop     <= 1'b0;
        end else begin
            if (ar_valid && bus.arready) begin
                ar_valid <= 1'b0;
                r_wait   <= 1'b1;
            end
            if (r_fire) begin
                r_wait <= 1'b0;
                drop   <= 1'b0;
            end
            if (redirect) begin
                pc <= target;
                // the read in flight still has to finish, its line is thrown away
                if (ar_valid || (r_wait && !r_fire)) begin
                    drop <= 1'b1;
                end
            end else if (line_ok) begin
                pc <= pc + `FE_ADDR_W'(16);
            end
            // no new line is requested while the queue is stalled, so loads can still reach the bus
            if (!ar_valid && !r_wait && (redirect || !fifo_stall_req)) begin
                ar_valid <= 1'b1;
                ar_addr  <= redirect ? target : pc;
            end
        end
    end

    // low half of the line is the older instruction
    assign w_ena_1  = line_ok;
    assign w_ena_2  = line_ok;
    assign w_slot_1 = '{inst: bus.rdata[`FE_XLEN-1:0], pc: ar_addr};
    assign w_slot_2 = '{inst: bus.rdata[`FE_LINE_W-1 -: `FE_XLEN],
                        pc: ar_addr + `FE_ADDR_W'(8)};

    ar_stable: assert property (@(posedge clk) disable iff (reset)
        bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr));

endmodule

/* frontend_config.svh */
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// instruction and load data width
`define FE_XLEN 64

// byte address width on the read bus
`define FE_ADDR_W 32

// one bus beat carries a line of two instructions
`define FE_LINE_W 128

// queue holds 1 << FE_QDEPTH_LOG2 entries
`define FE_QDEPTH_LOG2 4

// lowest bit of the 4-bit opcode field in an instruction word
`define FE_OPC_LSB 60

`endif

/* frontend_top.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

module frontend_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  redirect,
    input  logic [`FE_ADDR_W-1:0] redirect_pc,
    input  logic                  hold,
    output logic [`FE_ADDR_W-1:0] araddr,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [`FE_LINE_W-1:0] rdata,
    input  bus_pkg::axi_resp_e    rresp,
    input  logic                  rvalid,
    output logic                  rready,
    output logic                  retire_valid_0,
    output logic                  retire_valid_1,
    output logic [`FE_ADDR_W-1:0] retire_pc_0,
    output logic [`FE_ADDR_W-1:0] retire_pc_1,
    output logic [`FE_XLEN-1:0]   retire_inst_0,
    output logic [`FE_XLEN-1:0]   retire_inst_1,
    output logic                  load_valid,
    output logic [`FE_XLEN-1:0]   load_data
);
    import fe_types_pkg::*;

    queue_slot_t w_slot_1;
    queue_slot_t w_slot_2;
    queue_slot_t r_slot_1;
    queue_slot_t r_slot_2;
    logic        w_ena_1;
    logic        w_ena_2;
    logic        r_ok_1;
    logic        r_ok_2;
    logic        pop_1;
    logic        pop_2;
    logic        fifo_stall_req;

    axil_rd_if fetch_bus ();
    axil_rd_if load_bus ();
    axil_rd_if mem_bus ();

    // shared read port out to memory
    assign araddr          = mem_bus.araddr;
    assign arvalid         = mem_bus.arvalid;
    assign rready          = mem_bus.rready;
    assign mem_bus.arready = arready;
    assign mem_bus.rdata   = rdata;
    assign mem_bus.rresp   = rresp;
    assign mem_bus.rvalid  = rvalid;

    fetch_unit u_fetch (
        .clk            (clk),
        .reset          (reset),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .bus            (fetch_bus.manager),
        .fifo_stall_req (fifo_stall_req),
        .w_ena_1        (w_ena_1),
        .w_ena_2        (w_ena_2),
        .w_slot_1       (w_slot_1),
        .w_slot_2       (w_slot_2)
    );

    inst_queue u_queue (
        .clk            (clk),
        .reset          (reset),
        .flush          (redirect),
        .w_ena_1        (w_ena_1),
        .w_ena_2        (w_ena_2),
        .w_slot_1       (w_slot_1),
        .w_slot_2       (w_slot_2),
        .pop_1          (pop_1),
        .pop_2          (pop_2),
        .r_slot_1       (r_slot_1),
        .r_slot_2       (r_slot_2),
        .r_ok_1         (r_ok_1),
        .r_ok_2         (r_ok_2),
        .fifo_stall_req (fifo_stall_req)
    );

    issue_unit u_issue (
        .clk            (clk),
        .reset          (reset),
        .flush          (redirect),
        .hold           (hold),
        .r_slot_1       (r_slot_1),
        .r_slot_2       (r_slot_2),
        .r_ok_1         (r_ok_1),
        .r_ok_2         (r_ok_2),
        .pop_1          (pop_1),
        .pop_2          (pop_2),
        .bus            (load_bus.manager),
        .retire_valid_0 (retire_valid_0),
        .retire_valid_1 (retire_valid_1),
        .retire_pc_0    (retire_pc_0),
        .retire_pc_1    (retire_pc_1),
        .retire_inst_0  (retire_inst_0),
        .retire_inst_1  (retire_inst_1),
        .load_valid     (load_valid),
        .load_data      (load_data)
    );

    mem_arbiter u_arb (
        .clk   (clk),
        .reset (reset),
        .m0    (fetch_bus.subordinate),
        .m1    (load_bus.subordinate),
        .s     (mem_bus.manager)
    );

endmodule

/* inst_queue.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

module inst_queue (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      w_ena_1,
    input  logic                      w_ena_2,
    input  fe_types_pkg::queue_slot_t w_slot_1,
    input  fe_types_pkg::queue_slot_t w_slot_2,
    input  logic                      pop_1,
    input  logic                      pop_2,
    output fe_types_pkg::queue_slot_t r_slot_1,
    output fe_types_pkg::queue_slot_t r_slot_2,
    output logic                      r_ok_1,
    output logic                      r_ok_2,
    output logic                      fifo_stall_req
);
    import fe_types_pkg::*;

    localparam int AW    = `FE_QDEPTH_LOG2;
    localparam int PW    = AW + 1;
    localparam int DEPTH = 1 << AW;

    typedef enum logic [1:0] {
        NORMAL = 2'b00,
        WAIT_1 = 2'b01,
        WAIT_2 = 2'b10
    } wait_state_e;

    wait_state_e   state;
    wait_state_e   next_state;
    queue_slot_t   queue [DEPTH];
    queue_slot_t   wait_reg_1;
    queue_slot_t   wait_reg_2;
    queue_slot_t   wd_1;
    queue_slot_t   wd_2;
    queue_slot_t   wait_d_1;
    logic [PW-1:0] w_ptr;
    logic [PW-1:0] r_ptr;
    logic [PW-1:0] w_ptr_inc;
    logic [PW-1:0] r_ptr_inc;
    logic [PW-1:0] used;
    logic          full;
    logic          left_one;
    logic          we_1;
    logic          we_2;
    logic          ld_wait_1;
    logic          ld_wait_2;

    assign w_ptr_inc = w_ptr + PW'(1);
    assign r_ptr_inc = r_ptr + PW'(1);
    assign used      = w_ptr - r_ptr;
    assign full      = (used == PW'(DEPTH));
    assign left_one  = (used == PW'(DEPTH - 1));

    assign r_ok_1   = (used != '0);
    assign r_ok_2   = (used > PW'(1));
    assign r_slot_1 = queue[r_ptr[AW-1:0]];
    assign r_slot_2 = queue[r_ptr_inc[AW-1:0]];

    // stall only after an overflow has been parked in the holding registers
    assign fifo_stall_req = (state != NORMAL);

    // ******************************
    // write side
    // ******************************

    always_comb begin
        next_state = state;
        we_1       = 1'b0;
        we_2       = 1'b0;
        wd_1       = w_slot_1;
        wd_2       = w_slot_2;
        ld_wait_1  = 1'b0;
        ld_wait_2  = 1'b0;
        wait_d_1   = w_slot_1;
        unique case (state)
            NORMAL: begin
                if (w_ena_1 && w_ena_2) begin
                    if (full) begin
                        next_state = WAIT_2;
                        ld_wait_1  = 1'b1;
                        ld_wait_2  = 1'b1;
                    end else if (left_one) begin
                        next_state = WAIT_1;
                        we_1       = 1'b1;
                        ld_wait_1  = 1'b1;
                        wait_d_1   = w_slot_2;
                    end else begin
                        we_1 = 1'b1;
                        we_2 = 1'b1;
                    end
                end else if (w_ena_1) begin
                    if (full) begin
                        next_state = WAIT_1;
                        ld_wait_1  = 1'b1;
                    end else begin
                        we_1 = 1'b1;
                    end
                end
            end
            WAIT_1: begin
                if (pop_1) begin
                    next_state = NORMAL;
                    we_1       = 1'b1;
                    wd_1       = wait_reg_1;
                end
            end
            WAIT_2: begin
                if (pop_1 && pop_2) begin
                    next_state = NORMAL;
                    we_1       = 1'b1;
                    we_2       = 1'b1;
                    wd_1       = wait_reg_1;
                    wd_2       = wait_reg_2;
                end else if (pop_1) begin
                    // older held entry goes in, younger one moves up
                    next_state = WAIT_1;
                    we_1       = 1'b1;
                    wd_1       = wait_reg_1;
                    ld_wait_1  = 1'b1;
                    wait_d_1   = wait_reg_2;
                end
            end
            default: next_state = NORMAL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (we_1) begin
            queue[w_ptr[AW-1:0]] <= wd_1;
        end
        if (we_2) begin
            queue[w_ptr_inc[AW-1:0]] <= wd_2;
        end
        if (ld_wait_1) begin
            wait_reg_1 <= wait_d_1;
        end
        if (ld_wait_2) begin
            wait_reg_2 <= w_slot_2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            w_ptr <= '0;
            r_ptr <= '0;
            state <= NORMAL;
        end else begin
            state <= next_state;
            w_ptr <= w_ptr + PW'(we_1) + PW'(we_2);
            r_ptr <= r_ptr + PW'(pop_1 && r_ok_1) + PW'(pop_2 && r_ok_2);
        end
    end

    no_write_in_stall: assert property (@(posedge clk) disable iff (reset)
        fifo_stall_req |-> !(w_ena_1 || w_ena_2));

    pop_order: assert property (@(posedge clk) disable iff (reset)
        pop_2 |-> pop_1);

    pop_in_range: assert property (@(posedge clk) disable iff (reset)
        (pop_1 |-> r_ok_1) and (pop_2 |-> r_ok_2));

endmodule

/* issue_unit.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

module issue_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      hold,
    input  fe_types_pkg::queue_slot_t r_slot_1,
    input  fe_types_pkg::queue_slot_t r_slot_2,
    input  logic                      r_ok_1,
    input  logic                      r_ok_2,
    output logic                      pop_1,
    output logic                      pop_2,
    axil_rd_if.manager                bus,
    output logic                      retire_valid_0,
    output logic                      retire_valid_1,
    output logic [`FE_ADDR_W-1:0]     retire_pc_0,
    output logic [`FE_ADDR_W-1:0]     retire_pc_1,
    output logic [`FE_XLEN-1:0]       retire_inst_0,
    output logic [`FE_XLEN-1:0]       retire_inst_1,
    output logic                      load_valid,
    output logic [`FE_XLEN-1:0]       load_data
);
    import fe_types_pkg::*;

    issue_state_e state;
    queue_slot_t  ld_slot;
    logic         drop;
    logic         load_1;
    logic         load_2;
    logic         r_fire;

    assign load_1 = (opcode_e'(r_slot_1.inst[`FE_OPC_LSB +: 4]) == LOAD);
    assign load_2 = (opcode_e'(r_slot_2.inst[`FE_OPC_LSB +: 4]) == LOAD);

    // a load only ever leaves the queue alone, from the head
    assign pop_1 = (state == READY) && !hold && !flush && r_ok_1;
    assign pop_2 = pop_1 && !load_1 && r_ok_2 && !load_2;

    assign bus.araddr  = {ld_slot.inst[`FE_ADDR_W-1:4], 4'b0000};
    assign bus.arvalid = (state == LOAD_ADDR);
    assign bus.rready  = (state == LOAD_DATA);
    assign r_fire      = bus.rvalid && bus.rready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= READY;
            drop           <= 1'b0;
            retire_valid_0 <= 1'b0;
            retire_valid_1 <= 1'b0;
            load_valid     <= 1'b0;
        end else begin
            retire_valid_0 <= pop_1 && !load_1;
            retire_valid_1 <= pop_2;
            load_valid     <= 1'b0;
            unique case (state)
                READY: begin
                    if (pop_1 && load_1) begin
                        state <= LOAD_ADDR;
                    end
                end
                LOAD_ADDR: begin
                    if (bus.arready) begin
                        state <= LOAD_DATA;
                    end
                end
                LOAD_DATA: begin
                    if (r_fire) begin
                        state <= READY;
                        drop  <= 1'b0;
                        if (!drop && !flush) begin
                            retire_valid_0 <= 1'b1;
                            load_valid     <= 1'b1;
                        end
                    end
                end
                default: state <= READY;
            endcase
            // the bus read has to run to its end, only its result is cancelled
            if (flush && state != READY && !r_fire) begin
                drop <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_1 && load_1) begin
            ld_slot <= r_slot_1;
        end
        if (state == READY) begin
            retire_pc_0   <= r_slot_1.pc;
            retire_inst_0 <= r_slot_1.inst;
            retire_pc_1   <= r_slot_2.pc;
            retire_inst_1 <= r_slot_2.inst;
        end else if (r_fire) begin
            retire_pc_0   <= ld_slot.pc;
            retire_inst_0 <= ld_slot.inst;
            load_data     <= ld_slot.inst[3] ? bus.rdata[`FE_LINE_W-1 -: `FE_XLEN]
                                             : bus.rdata[`FE_XLEN-1:0];
        end
    end

    // a pair always comes from neighbouring queue entries of one stream
    pair_order: assert property (@(posedge clk) disable iff (reset)
        retire_valid_1 |-> retire_valid_0 && (retire_pc_1 == retire_pc_0 + `FE_ADDR_W'(8)));

endmodule

/* list.f */
+incdir+.
fe_types_pkg.sv
bus_pkg.sv
axil_rd_if.sv
fetch_unit.sv
inst_queue.sv
issue_unit.sv
mem_arbiter.sv
frontend_top.sv
tb_frontend.sv

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic           clk,
    input  logic           reset,
    axil_rd_if.subordinate m0,
    axil_rd_if.subordinate m1,
    axil_rd_if.manager     s
);
    import bus_pkg::*;

    arb_state_e state;
    mgr_idx_t   grant;
    mgr_idx_t   last_grant;
    mgr_idx_t   winner;
    logic       sel_1;
    logic       r_fire;

    // on a tie the manager that was not served last goes first
    always_comb begin
        if (m0.arvalid && m1.arvalid) begin
            winner = ~last_grant;
        end else if (m1.arvalid) begin
            winner = MGR_ISSUE;
        end else begin
            winner = MGR_FETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            grant      <= MGR_FETCH;
            last_grant <= MGR_ISSUE;
        end else begin
            unique case (state)
                IDLE: begin
                    if (m0.arvalid || m1.arvalid) begin
                        grant <= winner;
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (s.arvalid && s.arready) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (r_fire) begin
                        state      <= IDLE;
                        last_grant <= grant;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign sel_1  = (grant == MGR_ISSUE);
    assign r_fire = s.rvalid && s.rready;

    assign s.araddr  = sel_1 ? m1.araddr : m0.araddr;
    assign s.arvalid = (state == ADDR) && (sel_1 ? m1.arvalid : m0.arvalid);
    assign s.rready  = (state == DATA) && (sel_1 ? m1.rready : m0.rready);

    assign m0.arready = (state == ADDR) && !sel_1 && s.arready;
    assign m1.arready = (state == ADDR) && sel_1 && s.arready;
    assign m0.rvalid  = (state == DATA) && !sel_1 && s.rvalid;
    assign m1.rvalid  = (state == DATA) && sel_1 && s.rvalid;
    assign m0.rdata   = s.rdata;
    assign m1.rdata   = s.rdata;
    assign m0.rresp   = s.rresp;
    assign m1.rresp   = s.rresp;

    no_r_in_idle: assert property (@(posedge clk) disable iff (reset)
        state == IDLE |-> !s.rvalid);

endmodule

/* tb_frontend.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

module tb_frontend;
    import fe_types_pkg::*;
    import bus_pkg::*;

    localparam int RUN_CYCLES = 6000;
    localparam int WAIT_LIMIT = 1000;

    logic                  clk;
    logic                  reset;
    logic                  redirect;
    logic [`FE_ADDR_W-1:0] redirect_pc;
    logic                  hold;
    logic [`FE_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [`FE_LINE_W-1:0] rdata;
    axi_resp_e             rresp;
    logic                  rvalid;
    logic                  rready;
    logic                  retire_valid_0;
    logic                  retire_valid_1;
    logic [`FE_ADDR_W-1:0] retire_pc_0;
    logic [`FE_ADDR_W-1:0] retire_pc_1;
    logic [`FE_XLEN-1:0]   retire_inst_0;
    logic [`FE_XLEN-1:0]   retire_inst_1;
    logic                  load_valid;
    logic [`FE_XLEN-1:0]   load_data;

    int unsigned           rng_state = 253;
    logic [`FE_ADDR_W-1:0] exp_pc;
    bit                    line_seen;
    bit                    stall_seen;
    int unsigned           retired;
    int unsigned           loads;
    int unsigned           redirects;
    int unsigned           hold_left;

    frontend_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ******************************
    // random source and memory image
    // ******************************

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 12;
    endfunction

    // every word is a mix of its full address, the top nibble is forced to a known opcode
    function automatic logic [`FE_XLEN-1:0] word_at(input logic [`FE_ADDR_W-1:0] addr);
        logic [63:0] h;
        h = {addr ^ 32'h9e3779b9, addr * 32'h85ebca6b};
        h = h ^ (h >> 29);
        h = h * 64'hbf58476d1ce4e5b9;
        h = h ^ (h >> 31);
        case (h[2:0])
            3'd0:    h[`FE_OPC_LSB +: 4] = NOP;
            3'd1:    h[`FE_OPC_LSB +: 4] = LOAD;
            3'd2:    h[`FE_OPC_LSB +: 4] = ILLEGAL;
            default: h[`FE_OPC_LSB +: 4] = ALU;
        endcase
        // loads point into the data region at 0x8000_0000
        if (h[`FE_OPC_LSB +: 4] == LOAD) begin
            h[31:0] = {16'h8000, h[15:3], 3'b000};
        end
        return h;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    // ******************************
    // memory side of the read bus
    // ******************************

    task automatic serve_reads();
        int unsigned           waited;
        int unsigned           ar_delay;
        int unsigned           r_delay;
        logic [`FE_ADDR_W-1:0] addr;
        forever begin
            waited = 0;
            @(negedge clk);
            while (!arvalid) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("no read request reached the memory in time");
                end
                @(negedge clk);
            end
            addr     = araddr;
            ar_delay = next_rand() % 4;
            r_delay  = next_rand() % 4;
            check_value("araddr[3:0]", addr[3:0], 0);
            // arvalid and araddr have to stay put while arready is low
            repeat (ar_delay) begin
                @(negedge clk);
                check_value("arvalid", arvalid, 1);
                check_value("araddr", araddr, addr);
            end
            @(posedge clk);
            #1;
            arready = 1'b1;
            @(negedge clk);
            check_value("arvalid", arvalid, 1);
            check_value("araddr", araddr, addr);
            @(posedge clk);
            #1;
            arready = 1'b0;
            repeat (r_delay) begin
                @(posedge clk);
                #1;
            end
            rvalid = 1'b1;
            rdata  = {word_at(addr + 32'd8), word_at(addr)};
            waited = 0;
            @(negedge clk);
            while (!rready) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("read data was never accepted by the front end");
                end
                @(negedge clk);
            end
            @(posedge clk);
            line_seen = 1'b1;
            #1;
            rvalid = 1'b0;
        end
    endtask

    task automatic drive_controls();
        if (hold_left > 0) begin
            hold_left--;
        end else if ((next_rand() % 60) == 0) begin
            hold_left = 60 + next_rand() % 60;
        end
        hold = (hold_left > 0);
        if (!redirect && !hold && (next_rand() % 64) == 0) begin
            redirect    = 1'b1;
            redirect_pc = (next_rand() % 32'h10000) & 32'hfff0;
            redirects++;
        end else begin
            redirect = 1'b0;
        end
    endtask

    task automatic check_outputs();
        logic [`FE_XLEN-1:0] word;
        if (u_dut.fifo_stall_req) begin
            stall_seen = 1'b1;
        end
        if (!line_seen) begin
            check_value("retire_valid_0", retire_valid_0, 0);
            check_value("retire_valid_1", retire_valid_1, 0);
            check_value("load_valid", load_valid, 0);
        end
        if (retire_valid_0) begin
            word = word_at(exp_pc);
            check_value("retire_pc_0", retire_pc_0, exp_pc);
            check_value("retire_inst_0", retire_inst_0, word);
            check_value("load_valid", load_valid, word[`FE_OPC_LSB +: 4] == LOAD);
            if (word[`FE_OPC_LSB +: 4] == LOAD) begin
                check_value("load_data", load_data, word_at({word[31:3], 3'b000}));
                loads++;
            end
            exp_pc = exp_pc + 32'd8;
            retired++;
        end else begin
            check_value("load_valid", load_valid, 0);
        end
        if (retire_valid_1) begin
            // slot 1 is the younger of a pair and never a load
            word = word_at(exp_pc);
            check_value("retire_valid_0", retire_valid_0, 1);
            check_value("retire_pc_1", retire_pc_1, exp_pc);
            check_value("retire_inst_1", retire_inst_1, word);
            check_value("retire_inst_1 is LOAD", word[`FE_OPC_LSB +: 4] == LOAD, 0);
            exp_pc = exp_pc + 32'd8;
            retired++;
        end
    endtask

    initial begin
        int unsigned idle;
        int unsigned last_retired;
        reset       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        hold        = 1'b0;
        arready     = 1'b0;
        rdata       = '0;
        rresp       = OKAY;
        rvalid      = 1'b0;
        exp_pc      = '0;
        idle        = 0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("arvalid", arvalid, 0);
        check_value("rready", rready, 0);
        check_value("fifo_stall_req", u_dut.fifo_stall_req, 0);
        check_outputs();
        fork
            serve_reads();
        join_none
        for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            @(posedge clk);
            #1;
            drive_controls();
            last_retired = retired;
            @(negedge clk);
            // results seen in a redirect cycle still belong to the old stream
            check_outputs();
            if (redirect) begin
                exp_pc = redirect_pc;
            end
            idle = (retired == last_retired) ? idle + 1 : 0;
            if (idle > WAIT_LIMIT) begin
                abort_run("no instruction retired for too many cycles");
            end
        end
        if (retired < 500 || loads == 0 || redirects == 0 || !stall_seen) begin
            abort_run($sformatf("too little activity: %0d retired, %0d loads, %0d redirects",
                                retired, loads, redirects));
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule
